// ==== src/core_pkg.sv ====
// shared widths and encodings for the mem/wb pipeline end; codes follow rv32 funct3 where they apply
package core_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	// outgoing cop word is {1'b0, nc, cop}
	localparam int l1d_cop_w  = 4;

	// --------------------
	// access size seen by the cache and the lane logic
	// --------------------
	typedef logic [2:0] access_size_t;

	localparam access_size_t size_byte = 3'd0;
	localparam access_size_t size_half = 3'd1;
	localparam access_size_t size_word = 3'd2;

	// --------------------
	// load extension, funct3 meaning
	// --------------------
	typedef logic [2:0] sx_op_t;

	localparam sx_op_t lb  = 3'd0;
	localparam sx_op_t lh  = 3'd1;
	localparam sx_op_t lw  = 3'd2;
	localparam sx_op_t lbu = 3'd4;
	localparam sx_op_t lhu = 3'd5;

	// cache operation
	typedef logic [1:0] l1d_cop_t;

	localparam l1d_cop_t cop_load  = 2'd0;
	localparam l1d_cop_t cop_store = 2'd1;

	// one cache word, seen whole or lane by lane
	typedef union packed {
		logic [xlen-1:0]  word;
		logic [3:0][7:0]  lanes;
	} load_word_u;

endpackage

// ==== src/core_load_align.sv ====
// byte_off must suit the access size; halfword picks use byte_off[1] only
`timescale 1ns/1ps

module core_load_align import core_pkg::*; (
	input  logic [xlen-1:0] rsp_data,
	input  logic [1:0]      byte_off,
	input  sx_op_t          sx_op,
	output logic [xlen-1:0] load_value
);

	load_word_u  rsp_word;
	logic [7:0]  sel_byte;
	logic [15:0] sel_half;

	assign rsp_word.word = rsp_data;

	// lane pick
	assign sel_byte = rsp_word.lanes[byte_off];
	assign sel_half = byte_off[1] ? rsp_word.word[31:16] : rsp_word.word[15:0];

	// --------------------
	// extension
	// --------------------
	always_comb begin
		case (sx_op)
			lb: begin
				load_value = {{(xlen-8){sel_byte[7]}}, sel_byte};
			end
			lh: begin
				load_value = {{(xlen-16){sel_half[15]}}, sel_half};
			end
			lbu: begin
				load_value = {{(xlen-8){1'b0}}, sel_byte};
			end
			lhu: begin
				load_value = {{(xlen-16){1'b0}}, sel_half};
			end
			lw: begin
				load_value = rsp_word.word;
			end
			default: begin
				// unused codes fall back to the whole word
				load_value = rsp_word.word;
			end
		endcase
	end

endmodule

// ==== src/core_mem_s.sv ====
// request outputs are combinational from the inputs; kill beats enable; no misaligned-access check
`timescale 1ns/1ps

module core_mem_s import core_pkg::*; #(
	parameter logic [xlen-1:0] nc_base = '0,
	parameter logic [xlen-1:0] nc_mask = '0
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  mem_enb,
	input  logic                  mem_kill,
	input  logic                  val_inst,
	// data from execute
	input  logic [xlen-1:0]       alu_result,
	input  logic [xlen-1:0]       pc_4,
	input  logic [xlen-1:0]       wrt_data,
	// control from execute
	input  sx_op_t                wb_sx_op,
	input  logic                  we_reg_file,
	input  logic                  sel_mem,
	input  logic [reg_addr_w-1:0] rd,
	input  logic                  l1d_req_val_in,
	input  l1d_cop_t              l1d_req_cop_in,
	input  access_size_t          l1d_req_size_in,
	// store-data bypass from write-back
	input  logic                  bp_sel,
	input  logic [xlen-1:0]       bp_wb_data,
	// l1d request
	output logic                  l1d_req_val,
	output logic [l1d_cop_w-1:0]  l1d_req_cop,
	output access_size_t          l1d_req_size,
	output logic [xlen-1:0]       l1d_req_addr,
	output logic [xlen-1:0]       l1d_req_wdata,
	// forwarding back to execute
	output logic [xlen-1:0]       exe_bp_data,
	// stage register towards write-back
	output logic [xlen-1:0]       wb_alu_result,
	output logic [xlen-1:0]       wb_pc_4,
	output logic                  wb_we,
	output logic                  wb_sel_mem,
	output sx_op_t                wb_sx_op_r,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic                  wb_val
);

	logic [xlen-1:0] st_data;
	logic            non_cacheable;

	// --------------------
	// stage register
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n || mem_kill) begin
			wb_alu_result <= '0;
			wb_pc_4       <= '0;
			wb_we         <= 1'b0;
			wb_sel_mem    <= 1'b0;
			wb_sx_op_r    <= '0;
			wb_rd         <= '0;
			wb_val        <= 1'b0;
		end else if (mem_enb) begin
			wb_alu_result <= alu_result;
			wb_pc_4       <= pc_4;
			wb_we         <= we_reg_file;
			wb_sel_mem    <= sel_mem;
			wb_sx_op_r    <= wb_sx_op;
			wb_rd         <= rd;
			wb_val        <= val_inst;
		end
	end

	// --------------------
	// l1d request
	// --------------------
	// address bits outside the mask must match the base
	assign non_cacheable = ((alu_result & ~nc_mask) == nc_base);

	assign l1d_req_val  = l1d_req_val_in;
	assign l1d_req_cop  = {1'b0, non_cacheable, l1d_req_cop_in};
	assign l1d_req_size = l1d_req_size_in;
	assign l1d_req_addr = alu_result;

	// store data, bypassed value wins when selected
	assign st_data = bp_sel ? bp_wb_data : wrt_data;

	// replicate low bytes so every lane carries the data
	always_comb begin
		case (l1d_req_size_in)
			size_byte: l1d_req_wdata = {4{st_data[7:0]}};
			size_half: l1d_req_wdata = {2{st_data[15:0]}};
			size_word: l1d_req_wdata = st_data;
			default:   l1d_req_wdata = st_data;
		endcase
	end

	// unregistered alu result for execute forwarding
	assign exe_bp_data = alu_result;

endmodule

// ==== src/core_wb_s.sv ====
// purely combinational; the load response must stay valid for as long as the stage holds
`timescale 1ns/1ps

module core_wb_s import core_pkg::*; (
	// from the memory-stage register
	input  logic [xlen-1:0]       wb_alu_result,
	input  logic                  wb_we,
	input  logic                  wb_sel_mem,
	input  sx_op_t                wb_sx_op,
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic                  wb_val,
	// fixed-latency load word from l1d
	input  logic [xlen-1:0]       l1d_rsp_data,
	// register-file write port
	output logic                  rf_we,
	output logic [reg_addr_w-1:0] rf_rd,
	output logic [xlen-1:0]       rf_wdata
);

	logic [xlen-1:0] load_value;
	logic            rd_is_zero;

	// --------------------
	// load alignment
	// --------------------
	core_load_align i_core_load_align (
		.rsp_data   (l1d_rsp_data),
		.byte_off   (wb_alu_result[1:0]),
		.sx_op      (wb_sx_op),
		.load_value (load_value)
	);

	// --------------------
	// result select
	// --------------------
	assign rf_wdata = wb_sel_mem ? load_value : wb_alu_result;

	// x0 is never written
	assign rd_is_zero = (wb_rd == '0);

	assign rf_we = wb_we && wb_val && !rd_is_zero;
	assign rf_rd = wb_rd;

endmodule

// ==== src/core_mem_wb.sv ====
// nc window set by parameters; no back-pressure, stall only through mem_enb
`timescale 1ns/1ps

module core_mem_wb import core_pkg::*; #(
	parameter logic [xlen-1:0] nc_base = 32'h4000_0000,
	parameter logic [xlen-1:0] nc_mask = 32'h0FFF_FFFF
) (
	input  logic                  clk,
	input  logic                  rst_n,
	// stage strobes
	input  logic                  mem_enb,
	input  logic                  mem_kill,
	input  logic                  val_inst,
	// execute results
	input  logic [xlen-1:0]       alu_result,
	input  logic [xlen-1:0]       pc_4,
	input  logic [xlen-1:0]       wrt_data,
	input  sx_op_t                wb_sx_op,
	input  logic                  we_reg_file,
	input  logic                  sel_mem,
	input  logic [reg_addr_w-1:0] rd,
	input  logic                  l1d_req_val_in,
	input  l1d_cop_t              l1d_req_cop_in,
	input  access_size_t          l1d_req_size_in,
	input  logic                  bp_sel,
	// l1d
	output logic                  l1d_req_val,
	output logic [l1d_cop_w-1:0]  l1d_req_cop,
	output access_size_t          l1d_req_size,
	output logic [xlen-1:0]       l1d_req_addr,
	output logic [xlen-1:0]       l1d_req_wdata,
	input  logic [xlen-1:0]       l1d_rsp_data,
	// forwarding and observe
	output logic [xlen-1:0]       exe_bp_data,
	output logic [xlen-1:0]       wb_pc_4,
	// register file
	output logic                  rf_we,
	output logic [reg_addr_w-1:0] rf_rd,
	output logic [xlen-1:0]       rf_wdata
);

	// --------------------
	// mem to wb
	// --------------------
	logic [xlen-1:0]       wb_alu_result;
	logic                  wb_we;
	logic                  wb_sel_mem;
	sx_op_t                wb_sx_op_r;
	logic [reg_addr_w-1:0] wb_rd;
	logic                  wb_val;

	core_mem_s #(
		.nc_base (nc_base),
		.nc_mask (nc_mask)
	) i_core_mem_s (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_enb         (mem_enb),
		.mem_kill        (mem_kill),
		.val_inst        (val_inst),
		.alu_result      (alu_result),
		.pc_4            (pc_4),
		.wrt_data        (wrt_data),
		.wb_sx_op        (wb_sx_op),
		.we_reg_file     (we_reg_file),
		.sel_mem         (sel_mem),
		.rd              (rd),
		.l1d_req_val_in  (l1d_req_val_in),
		.l1d_req_cop_in  (l1d_req_cop_in),
		.l1d_req_size_in (l1d_req_size_in),
		.bp_sel          (bp_sel),
		// write-back result loops back as the store bypass
		.bp_wb_data      (rf_wdata),
		.l1d_req_val     (l1d_req_val),
		.l1d_req_cop     (l1d_req_cop),
		.l1d_req_size    (l1d_req_size),
		.l1d_req_addr    (l1d_req_addr),
		.l1d_req_wdata   (l1d_req_wdata),
		.exe_bp_data     (exe_bp_data),
		.wb_alu_result   (wb_alu_result),
		.wb_pc_4         (wb_pc_4),
		.wb_we           (wb_we),
		.wb_sel_mem      (wb_sel_mem),
		.wb_sx_op_r      (wb_sx_op_r),
		.wb_rd           (wb_rd),
		.wb_val          (wb_val)
	);

	core_wb_s i_core_wb_s (
		.wb_alu_result (wb_alu_result),
		.wb_we         (wb_we),
		.wb_sel_mem    (wb_sel_mem),
		.wb_sx_op      (wb_sx_op_r),
		.wb_rd         (wb_rd),
		.wb_val        (wb_val),
		.l1d_rsp_data  (l1d_rsp_data),
		.rf_we         (rf_we),
		.rf_rd         (rf_rd),
		.rf_wdata      (rf_wdata)
	);

endmodule

// ==== testbench/tb_core_mem_wb.sv ====
// L1D model is 256 words at address bits [9:2], load data one edge late; aligned accesses only
`timescale 1ns/1ps

module tb_core_mem_wb import core_pkg::*; ();

	localparam logic [31:0] nc_base    = 32'h4000_0000;
	localparam logic [31:0] nc_mask    = 32'h0FFF_FFFF;
	localparam int          wait_limit = 16;

	logic                  clk, rst_n, mem_enb, mem_kill, val_inst;
	logic [xlen-1:0]       alu_result, pc_4, wrt_data, l1d_rsp_data;
	sx_op_t                wb_sx_op;
	logic                  we_reg_file, sel_mem, l1d_req_val_in, bp_sel;
	logic [reg_addr_w-1:0] rd, rf_rd;
	l1d_cop_t              l1d_req_cop_in;
	access_size_t          l1d_req_size_in, l1d_req_size;
	logic                  l1d_req_val, rf_we;
	logic [l1d_cop_w-1:0]  l1d_req_cop;
	logic [xlen-1:0]       l1d_req_addr, l1d_req_wdata, exe_bp_data, wb_pc_4, rf_wdata;

	logic [31:0] mem [0:255];
	logic [3:0]  st_lanes;
	integer      seed = 32'h59;
	int          errors = 0;
	int          test_errors = 0;
	int          n_tests = 0;
	int          n_failed = 0;
	event        do_check;

	// one expected write-back per compare
	logic        q_we [$];
	logic [4:0]  q_rd [$];
	logic [31:0] q_data [$];
	logic [31:0] q_pc [$];

	core_mem_wb #(
		.nc_base (nc_base),
		.nc_mask (nc_mask)
	) i_core_mem_wb (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// --------------------
	// L1D model
	// --------------------
	assign st_lanes = (l1d_req_size == size_byte) ? 4'b0001 << l1d_req_addr[1:0] :
		(l1d_req_size == size_half) ? (l1d_req_addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;

	always @(posedge clk) begin
		if (l1d_req_val && l1d_req_cop[1:0] == cop_load) begin
			l1d_rsp_data <= mem[l1d_req_addr[9:2]];
		end else if (l1d_req_val) begin
			for (int i = 0; i < 4; i++) begin
				if (st_lanes[i])
					mem[l1d_req_addr[9:2]][8*i +: 8] <= l1d_req_wdata[8*i +: 8];
			end
		end
	end

	// expected register-file data from the load rules
	function automatic logic [31:0] exp_wb(logic [31:0] alu, logic [31:0] word,
			sx_op_t op, logic sel);
		logic [31:0] shifted;
		shifted = word >> (8 * alu[1:0]);
		if (!sel)
			return alu;
		case (op)
			lb:      return {{24{shifted[7]}}, shifted[7:0]};
			lbu:     return {24'h0, shifted[7:0]};
			lh:      return {{16{shifted[15]}}, shifted[15:0]};
			lhu:     return {16'h0, shifted[15:0]};
			default: return word;
		endcase
	endfunction

	task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	// compare process pops one queue entry per trigger
	always begin
		@(do_check);
		check_val("rf_we", rf_we, q_we.pop_front());
		check_val("rf_rd", rf_rd, q_rd.pop_front());
		check_val("rf_wdata", rf_wdata, q_data.pop_front());
		check_val("wb_pc_4", wb_pc_4, q_pc.pop_front());
	end

	// --------------------
	// stimulus helpers
	// --------------------
	task automatic drive_idle();
		mem_enb = 1'b1;
		mem_kill = 1'b0;
		val_inst = 1'b0;
		we_reg_file = 1'b0;
		sel_mem = 1'b0;
		l1d_req_val_in = 1'b0;
		bp_sel = 1'b0;
	endtask

	task automatic expect_wb(logic we, logic [4:0] rd_i, logic [31:0] data, logic [31:0] pc);
		q_we.push_back(we);
		q_rd.push_back(rd_i);
		q_data.push_back(data);
		q_pc.push_back(pc);
	endtask

	task automatic issue(logic [31:0] addr, logic [31:0] data, sx_op_t op, logic we,
			logic sel, logic [4:0] rd_i, logic req, l1d_cop_t cop, access_size_t size);
		drive_idle();
		val_inst = 1'b1;
		alu_result = addr;
		pc_4 = $random(seed);
		wrt_data = data;
		wb_sx_op = op;
		we_reg_file = we;
		sel_mem = sel;
		rd = rd_i;
		l1d_req_val_in = req;
		l1d_req_cop_in = cop;
		l1d_req_size_in = size;
		expect_wb(we && rd_i != 0, rd_i, exp_wb(addr, mem[addr[9:2]], op, sel), pc_4);
	endtask

	// accept on the next edge and wait for the write-back
	task automatic retire();
		int   lat;
		logic exp_we;
		exp_we = q_we[q_we.size()-1];
		@(negedge clk);
		drive_idle();
		lat = 1;
		while (exp_we && rf_we !== 1'b1 && lat < wait_limit) begin
			@(negedge clk);
			lat++;
		end
		if (lat != 1) begin
			$display("write-back not seen one edge after acceptance (%0d edges)", lat);
			test_errors++;
		end
		-> do_check;
	endtask

	task automatic end_test(string name);
		@(negedge clk);
		n_tests++;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			n_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		logic [31:0] a, d, x, p;
		logic        ok;
		rst_n = 1'b0;
		drive_idle();
		alu_result = '0;
		pc_4 = '0;
		wrt_data = '0;
		wb_sx_op = lw;
		l1d_req_cop_in = cop_load;
		l1d_req_size_in = size_word;
		l1d_rsp_data = '0;
		// a register write waits at the stage inputs for the whole reset
		val_inst = 1'b1;
		we_reg_file = 1'b1;
		rd = 5'd1;
		for (int i = 0; i < 256; i++)
			mem[i] = (i * 32'h0101_0101) ^ 32'h8c40_a5f3;

		for (int i = 0; i < 6; i++) begin
			@(negedge clk);
			check_val("rf_we", rf_we, 0);
			check_val("l1d_req_val", l1d_req_val, 0);
			if (i == 4) begin
				rst_n = 1'b1;
				drive_idle();
			end
		end
		end_test("reset");

		// rd of zero on the sixth one
		for (int i = 0; i < 8; i++) begin
			issue($random(seed), 0, lw, 1'b1, 1'b0, (i == 5) ? 5'd0 : 5'(i + 1), 1'b0,
				cop_load, size_word);
			retire();
		end
		end_test("alu_wb");

		for (int k = 0; k < 6; k++) begin
			for (int off = 0; off < 4; off++) begin
				ok = (k != 3) && !(k == 2 && off != 0) && !(k[0] && off[0]);
				if (ok) begin
					a = ($random(seed) & 32'h3FC) | off;
					issue(a, 0, sx_op_t'(k), 1'b1, 1'b1, 5'd9, 1'b1, cop_load, {1'b0, 2'(k)});
					retire();
				end
			end
		end
		end_test("loads");

		// first four inside the window and the rest outside
		for (int i = 0; i < 8; i++) begin
			x = $random(seed);
			a = (i < 4) ? (nc_base | (x & nc_mask)) :
				((x & ~nc_mask) == nc_base) ? (x ^ 32'h8000_0000) : x;
			alu_result = a;
			l1d_req_cop_in = l1d_cop_t'(i % 2);
			l1d_req_size_in = access_size_t'(i % 3);
			#2;
			check_val("l1d_req_cop", l1d_req_cop, {1'b0, 1'(i < 4), l1d_req_cop_in});
			check_val("l1d_req_addr", l1d_req_addr, a);
			check_val("l1d_req_size", l1d_req_size, i % 3);
			check_val("exe_bp_data", exe_bp_data, a);
			@(negedge clk);
		end
		end_test("non_cacheable");

		for (int s = 0; s < 3; s++) begin
			d = $random(seed);
			a = ($random(seed) & 32'h3FC) | ((s == 0) ? 2'd3 : (s == 1) ? 2'd2 : 2'd0);
			issue(a, d, lw, 1'b0, 1'b0, 5'd0, 1'b1, cop_store, s);
			#2;
			check_val("l1d_req_val", l1d_req_val, 1);
			check_val("l1d_req_wdata", l1d_req_wdata,
				(s == 0) ? {4{d[7:0]}} : (s == 1) ? {2{d[15:0]}} : d);
			retire();
			issue(a & ~32'h3, 0, lw, 1'b1, 1'b1, 5'd3, 1'b1, cop_load, size_word);
			retire();
		end
		// store data taken from the write-back result
		x = $random(seed);
		issue(x, 0, lw, 1'b1, 1'b0, 5'd6, 1'b0, cop_load, size_word);
		retire();
		issue(32'h0000_0100, $random(seed), lw, 1'b0, 1'b0, 5'd0, 1'b1, cop_store, size_word);
		bp_sel = 1'b1;
		#2;
		check_val("l1d_req_wdata", l1d_req_wdata, x);
		retire();
		end_test("stores");

		x = $random(seed);
		issue(x, 0, lw, 1'b1, 1'b0, 5'd7, 1'b0, cop_load, size_word);
		p = q_pc[q_pc.size()-1];
		retire();
		// new instruction waits while the stage holds
		val_inst = 1'b1;
		we_reg_file = 1'b1;
		alu_result = ~x;
		pc_4 = ~p;
		rd = 5'd8;
		mem_enb = 1'b0;
		for (int i = 0; i < 3; i++) begin
			expect_wb(1'b1, 5'd7, x, p);
			@(negedge clk);
			-> do_check;
		end
		mem_enb = 1'b1;
		mem_kill = 1'b1;
		expect_wb(1'b0, 5'd0, 32'h0, 32'h0);
		@(negedge clk);
		drive_idle();
		-> do_check;
		end_test("stall_kill");

		$display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#100000;
		$display("run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== core_mem_wb.f ====
src/core_pkg.sv
src/core_load_align.sv
src/core_mem_s.sv
src/core_wb_s.sv
src/core_mem_wb.sv
testbench/tb_core_mem_wb.sv

// ==== Bender.yml ====
package:
  name: core_mem_wb

sources:
  - src/core_pkg.sv
  - src/core_load_align.sv
  - src/core_mem_s.sv
  - src/core_wb_s.sv
  - src/core_mem_wb.sv
  - target: test
    files:
      - testbench/tb_core_mem_wb.sv
